// ==== hdl/rob_config.svh ====
`ifndef ROB_CONFIG_SVH
`define ROB_CONFIG_SVH

// reorder buffer entries, power of two
`define ROB_DEPTH 16

// architectural integer registers
`define REG_COUNT 32

// result width
`define XLEN 32

// program counter width
`define ADDR_W 32

`endif

// ==== hdl/rob_pkg.sv ====
`default_nettype none

`include "rob_config.svh"

package rob_pkg;

    // derived widths
    localparam int ROB_TAG_W  = $clog2(`ROB_DEPTH);
    localparam int REG_NAME_W = $clog2(`REG_COUNT);

    // index of an entry in the buffer
    typedef logic [ROB_TAG_W-1:0] rob_tag_t;

    // architectural register number
    typedef logic [REG_NAME_W-1:0] reg_name_t;

    // execution result
    typedef logic [`XLEN-1:0] data_t;

    // branch target, redirect pc
    typedef logic [`ADDR_W-1:0] addr_t;

endpackage

`default_nettype wire

// ==== hdl/wb_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface wb_bus_if;
    import rob_pkg::*;

    logic     valid;
    rob_tag_t tag;
    data_t    data;
    // resolved direction and target, only meaningful for branches
    logic     taken;
    addr_t    target;

    modport producer (
        output valid, tag, data, taken, target
    );

    modport rob (
        input valid, tag, data, taken, target
    );

endinterface

`default_nettype wire

// ==== hdl/commit_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface commit_if;
    import rob_pkg::*;

    // strobe, no back-pressure
    logic      valid;
    rob_tag_t  tag;
    reg_name_t rd;
    data_t     data;

    modport rob (
        output valid, tag, rd, data
    );

    // rename only needs the tag and rd to release a mapping
    modport rename (
        input valid, tag, rd
    );

endinterface

`default_nettype wire

// ==== hdl/rename_table.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rob_config.svh"

module rename_table (
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire                   flush,
    input  wire                   alloc_fire,
    input  wire rob_pkg::reg_name_t alloc_rd,
    input  wire rob_pkg::rob_tag_t  alloc_tag,
    commit_if.rename              cm,
    input  wire rob_pkg::reg_name_t rs1,
    input  wire rob_pkg::reg_name_t rs2,
    output logic                  rs1_busy,
    output rob_pkg::rob_tag_t     rs1_tag,
    output logic                  rs2_busy,
    output rob_pkg::rob_tag_t     rs2_tag
);
    import rob_pkg::*;

    // pending producer per register
    logic [`REG_COUNT-1:0] busy_q;
    rob_tag_t              tag_q [`REG_COUNT];

    logic commit_release;
    logic alloc_map;

    // only release if no younger producer took the register over
    assign commit_release = cm.valid && busy_q[cm.rd] && (tag_q[cm.rd] == cm.tag);

    // x0 is hardwired, never wait on it
    assign alloc_map = alloc_fire && (alloc_rd != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_q <= '0;
            for (int i = 0; i < `REG_COUNT; i++) begin
                tag_q[i] <= '0;
            end
        end else if (flush) begin
            busy_q <= '0;
        end else begin
            if (commit_release) begin
                busy_q[cm.rd] <= 1'b0;
            end
            // later assignment, so a new mapping beats a same-cycle release
            if (alloc_map) begin
                busy_q[alloc_rd] <= 1'b1;
                tag_q[alloc_rd]  <= alloc_tag;
            end
        end
    end

    // operand lookups
    always_comb begin
        rs1_busy = busy_q[rs1];
        rs1_tag  = tag_q[rs1];
        rs2_busy = busy_q[rs2];
        rs2_tag  = tag_q[rs2];
    end

    // the buffer must drop allocation while it flushes
    a_no_alloc_on_flush: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(alloc_fire && flush)
    );

endmodule

`default_nettype wire

// ==== hdl/reorder_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rob_config.svh"

module reorder_buffer (
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire                     alloc_en,
    input  wire rob_pkg::reg_name_t alloc_rd,
    input  wire                     alloc_is_store,
    input  wire                     alloc_is_branch,
    input  wire                     alloc_pred_taken,
    output logic                    alloc_fire,
    output logic                    full,
    output rob_pkg::rob_tag_t       alloc_tag,
    wb_bus_if.rob                   wb,
    commit_if.rob                   cm,
    output logic                    store_release,
    output rob_pkg::rob_tag_t       store_tag,
    output logic                    flush,
    output rob_pkg::addr_t          redirect_pc
);
    import rob_pkg::*;

    localparam int CNT_W = $clog2(`ROB_DEPTH) + 1;

    // per-entry control
    logic [`ROB_DEPTH-1:0] valid_q;
    logic [`ROB_DEPTH-1:0] done_q;

    // per-entry payload
    logic [`ROB_DEPTH-1:0] store_q;
    logic [`ROB_DEPTH-1:0] branch_q;
    logic [`ROB_DEPTH-1:0] pred_q;
    logic [`ROB_DEPTH-1:0] actual_q;
    reg_name_t             rd_q     [`ROB_DEPTH];
    data_t                 data_q   [`ROB_DEPTH];
    addr_t                 target_q [`ROB_DEPTH];

    rob_tag_t              head_q;
    rob_tag_t              tail_q;
    logic [CNT_W-1:0]      count_q;

    logic empty;
    logic head_ready;
    logic head_mispredict;
    logic retire;

    assign empty = (count_q == '0);
    assign full  = (count_q == CNT_W'(`ROB_DEPTH));

    assign alloc_tag = tail_q;
    // nothing new enters while the buffer is being wiped
    assign alloc_fire = alloc_en && !full && !flush;

    // head retirement decision, all from registered state
    assign head_ready      = !empty && valid_q[head_q] && done_q[head_q];
    assign head_mispredict = head_ready && branch_q[head_q]
                             && (pred_q[head_q] != actual_q[head_q]);
    assign retire          = head_ready;

    always_comb begin
        cm.valid      = head_ready && !store_q[head_q];
        cm.tag        = head_q;
        cm.rd         = rd_q[head_q];
        cm.data       = data_q[head_q];
        store_release = head_ready && store_q[head_q];
        store_tag     = head_q;
        flush         = head_mispredict;
        redirect_pc   = head_mispredict ? target_q[head_q] : '0;
    end

    // pointers and occupancy
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (alloc_fire) begin
                tail_q <= tail_q + 1'b1;
            end
            if (retire) begin
                head_q <= head_q + 1'b1;
            end
            case ({alloc_fire, retire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // occupancy and completion flags
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
            done_q  <= '0;
        end else if (flush) begin
            valid_q <= '0;
            done_q  <= '0;
        end else begin
            if (retire) begin
                valid_q[head_q] <= 1'b0;
                done_q[head_q]  <= 1'b0;
            end
            if (alloc_fire) begin
                valid_q[tail_q] <= 1'b1;
                done_q[tail_q]  <= 1'b0;
            end
            // results come back in any order, indexed by tag
            if (wb.valid) begin
                done_q[wb.tag] <= 1'b1;
            end
        end
    end

    // payload capture
    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            rd_q[tail_q]     <= alloc_rd;
            store_q[tail_q]  <= alloc_is_store;
            branch_q[tail_q] <= alloc_is_branch;
            pred_q[tail_q]   <= alloc_pred_taken;
        end
        if (wb.valid) begin
            data_q[wb.tag]   <= wb.data;
            actual_q[wb.tag] <= wb.taken;
            target_q[wb.tag] <= wb.target;
        end
    end

    // producers only report tags that are in flight
    a_wb_occupied: assert property (
        @(posedge clk) disable iff (!arst_n)
        wb.valid |-> valid_q[wb.tag]
    );

    // each tag completes once per allocation
    a_wb_not_done: assert property (
        @(posedge clk) disable iff (!arst_n)
        wb.valid |-> !done_q[wb.tag]
    );

    // count and head pointer agree on the oldest entry
    a_head_occupied: assert property (
        @(posedge clk) disable iff (!arst_n)
        !empty |-> valid_q[head_q]
    );

endmodule

`default_nettype wire

// ==== hdl/rob_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_core (
    input  wire                     clk,
    input  wire                     arst_n,
    // allocation
    input  wire                     alloc_en,
    input  wire rob_pkg::reg_name_t alloc_rd,
    input  wire                     alloc_is_store,
    input  wire                     alloc_is_branch,
    input  wire                     alloc_pred_taken,
    output logic                    alloc_fire,
    output logic                    full,
    output rob_pkg::rob_tag_t       alloc_tag,
    // writeback
    input  wire                     wb_valid,
    input  wire rob_pkg::rob_tag_t  wb_tag,
    input  wire rob_pkg::data_t     wb_data,
    input  wire                     wb_taken,
    input  wire rob_pkg::addr_t     wb_target,
    // commit
    output logic                    commit_valid,
    output rob_pkg::rob_tag_t       commit_tag,
    output rob_pkg::reg_name_t      commit_rd,
    output rob_pkg::data_t          commit_data,
    output logic                    store_release,
    output rob_pkg::rob_tag_t       store_tag,
    // mispredict recovery
    output logic                    flush,
    output rob_pkg::addr_t          redirect_pc,
    // operand lookups
    input  wire rob_pkg::reg_name_t rs1,
    input  wire rob_pkg::reg_name_t rs2,
    output logic                    rs1_busy,
    output rob_pkg::rob_tag_t       rs1_tag,
    output logic                    rs2_busy,
    output rob_pkg::rob_tag_t       rs2_tag
);

    wb_bus_if wb_bus ();
    commit_if cm_bus ();

    assign wb_bus.valid  = wb_valid;
    assign wb_bus.tag    = wb_tag;
    assign wb_bus.data   = wb_data;
    assign wb_bus.taken  = wb_taken;
    assign wb_bus.target = wb_target;

    assign commit_valid = cm_bus.valid;
    assign commit_tag   = cm_bus.tag;
    assign commit_rd    = cm_bus.rd;
    assign commit_data  = cm_bus.data;

    reorder_buffer reorder_buffer_inst (
        .clk              (clk),
        .arst_n           (arst_n),
        .alloc_en         (alloc_en),
        .alloc_rd         (alloc_rd),
        .alloc_is_store   (alloc_is_store),
        .alloc_is_branch  (alloc_is_branch),
        .alloc_pred_taken (alloc_pred_taken),
        .alloc_fire       (alloc_fire),
        .full             (full),
        .alloc_tag        (alloc_tag),
        .wb               (wb_bus.rob),
        .cm               (cm_bus.rob),
        .store_release    (store_release),
        .store_tag        (store_tag),
        .flush            (flush),
        .redirect_pc      (redirect_pc)
    );

    rename_table rename_table_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .flush      (flush),
        .alloc_fire (alloc_fire),
        .alloc_rd   (alloc_rd),
        .alloc_tag  (alloc_tag),
        .cm         (cm_bus.rename),
        .rs1        (rs1),
        .rs2        (rs2),
        .rs1_busy   (rs1_busy),
        .rs1_tag    (rs1_tag),
        .rs2_busy   (rs2_busy),
        .rs2_tag    (rs2_tag)
    );

endmodule

`default_nettype wire

// ==== verification/rob_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rob_config.svh"

module rob_core_tb;
    import rob_pkg::*;

    localparam int NUM_ROWS = 36;
    localparam int DEPTH    = `ROB_DEPTH;

    logic      clk;
    logic      arst_n;
    logic      alloc_en;
    reg_name_t alloc_rd;
    logic      alloc_is_store;
    logic      alloc_is_branch;
    logic      alloc_pred_taken;
    logic      alloc_fire;
    logic      full;
    rob_tag_t  alloc_tag;
    logic      wb_valid;
    rob_tag_t  wb_tag;
    data_t     wb_data;
    logic      wb_taken;
    addr_t     wb_target;
    logic      commit_valid;
    rob_tag_t  commit_tag;
    reg_name_t commit_rd;
    data_t     commit_data;
    logic      store_release;
    rob_tag_t  store_tag;
    logic      flush;
    addr_t     redirect_pc;
    reg_name_t rs1;
    reg_name_t rs2;
    logic      rs1_busy;
    rob_tag_t  rs1_tag;
    logic      rs2_busy;
    rob_tag_t  rs2_tag;

    // instruction table, one row per instruction in program order
    reg_name_t t_rd     [NUM_ROWS];
    logic      t_store  [NUM_ROWS];
    logic      t_branch [NUM_ROWS];
    logic      t_pred   [NUM_ROWS];
    logic      t_act    [NUM_ROWS];
    addr_t     t_target [NUM_ROWS];
    data_t     t_data   [NUM_ROWS];
    int        t_after  [NUM_ROWS];

    // program-order model
    rob_tag_t  q_tag [$];
    int        pend_row [$];
    rob_tag_t  pend_tag [$];
    reg_name_t m_rd     [DEPTH];
    data_t     m_data   [DEPTH];
    logic      m_store  [DEPTH];
    logic      m_mis    [DEPTH];
    logic      m_done   [DEPTH];
    addr_t     m_target [DEPTH];
    rob_tag_t  m_tail;
    logic      r_busy [`REG_COUNT];
    rob_tag_t  r_tag  [`REG_COUNT];

    logic [31:0] lfsr_q;

    rob_core rob_core_inst (.*);

    always #2 clk = ~clk;

    function automatic logic lfsr_bit();
        logic b;
        b = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (b) begin
            lfsr_q = lfsr_q ^ 32'h80200003;
        end
        return b;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    task automatic add_row(input int i, input reg_name_t rd, input logic st,
                           input logic br, input logic pred, input logic act,
                           input addr_t tgt, input data_t d, input int after);
        t_rd[i]     = rd;
        t_store[i]  = st;
        t_branch[i] = br;
        t_pred[i]   = pred;
        t_act[i]    = act;
        t_target[i] = tgt;
        t_data[i]   = d;
        t_after[i]  = after;
    endtask

    // hard limit on run length
    initial begin
        repeat (NUM_ROWS * 40) @(posedge clk);
        $display("timeout: the instruction table did not drain in time");
        $display("Checks failed");
        $fatal(1);
    end

    initial begin
        int        row_idx;
        int        stall;
        int        commits;
        int        flushed;
        int        wb_pick;
        int        k;
        int        r;
        logic      idle;
        logic      saw_full;
        logic      saw_flush;
        logic      exp_full;
        logic      exp_fire;
        logic      exp_cv;
        logic      exp_sr;
        logic      exp_flush;
        logic      last_cm;
        rob_tag_t  h;
        reg_name_t last_rd;
        reg_name_t last_cm_rd;

        clk = 0;
        arst_n = 0;
        alloc_en = 0;
        alloc_rd = '0;
        alloc_is_store = 0;
        alloc_is_branch = 0;
        alloc_pred_taken = 0;
        wb_valid = 0;
        wb_tag = '0;
        wb_data = '0;
        wb_taken = 0;
        wb_target = '0;
        rs1 = '0;
        rs2 = '0;
        lfsr_q = 32'hb403f258;
        row_idx = 0;
        stall = 0;
        commits = 0;
        flushed = 0;
        saw_full = 0;
        saw_flush = 0;
        last_cm = 0;
        last_rd = '0;
        last_cm_rd = '0;
        m_tail = '0;
        h = '0;
        for (r = 0; r < DEPTH; r++) begin
            m_done[r] = 0;
        end
        for (r = 0; r < `REG_COUNT; r++) begin
            r_busy[r] = 0;
            r_tag[r] = '0;
        end

        // out-of-order writebacks, stores, a correct branch
        add_row(0, 5'd1, 0, 0, 0, 0, '0, 32'h11, 3);
        add_row(1, 5'd2, 0, 0, 0, 0, '0, 32'h22, 1);
        add_row(2, 5'd1, 0, 0, 0, 0, '0, 32'h33, 0);
        add_row(3, 5'd0, 1, 0, 0, 0, '0, 32'h44, 2);
        add_row(4, 5'd5, 0, 0, 0, 0, '0, 32'h55, 4);
        add_row(5, 5'd6, 0, 0, 0, 0, '0, 32'h66, 0);
        add_row(6, 5'd7, 0, 1, 1, 1, 32'h200, 32'h77, 1);
        add_row(7, 5'd2, 0, 0, 0, 0, '0, 32'h88, 2);
        add_row(8, 5'd0, 1, 0, 0, 0, '0, 32'h99, 0);
        add_row(9, 5'd9, 0, 0, 0, 0, '0, 32'haa, 1);
        // mispredicted branch with younger rows behind it
        add_row(10, 5'd3, 0, 0, 0, 0, '0, 32'hbb, 3);
        add_row(11, 5'd4, 0, 1, 0, 1, 32'h1000, 32'hcc, 0);
        add_row(12, 5'd8, 0, 0, 0, 0, '0, 32'hdd, 5);
        add_row(13, 5'd10, 0, 0, 0, 0, '0, 32'hee, 5);
        // long latency rows, fill the buffer
        for (r = 14; r < NUM_ROWS; r++) begin
            add_row(r, reg_name_t'(11 + r % 6), 0, 0, 0, 0, '0, data_t'(32'h300 + r), 40);
        end

        repeat (16) @(posedge clk);
        #0.5;
        arst_n = 1;

        while (!(row_idx == NUM_ROWS && q_tag.size() == 0 && pend_row.size() == 0)) begin
            @(posedge clk);
            #0.5;
            exp_full  = (q_tag.size() == DEPTH);
            exp_cv    = 0;
            exp_sr    = 0;
            exp_flush = 0;
            if (q_tag.size() > 0) begin
                h = q_tag[0];
                if (m_done[h]) begin
                    exp_sr    = m_store[h];
                    exp_cv    = !m_store[h];
                    exp_flush = m_mis[h];
                end
            end
            stall = exp_full ? stall + 1 : 0;

            alloc_en = 0;
            if (row_idx < NUM_ROWS) begin
                idle = lfsr_bit() & lfsr_bit();
                if (!idle) begin
                    alloc_en         = 1;
                    alloc_rd         = t_rd[row_idx];
                    alloc_is_store   = t_store[row_idx];
                    alloc_is_branch  = t_branch[row_idx];
                    alloc_pred_taken = t_pred[row_idx];
                end
            end

            // oldest writeback whose turn has come
            wb_valid = 0;
            wb_pick = -1;
            for (k = 0; k < pend_row.size(); k++) begin
                if (wb_pick < 0 && (row_idx >= NUM_ROWS || stall >= 3 ||
                    row_idx >= pend_row[k] + 1 + t_after[pend_row[k]])) begin
                    wb_pick = k;
                end
            end
            if (wb_pick >= 0) begin
                wb_valid  = 1;
                wb_tag    = pend_tag[wb_pick];
                wb_data   = t_data[pend_row[wb_pick]];
                wb_taken  = t_act[pend_row[wb_pick]];
                wb_target = t_target[pend_row[wb_pick]];
                pend_row.delete(wb_pick);
                pend_tag.delete(wb_pick);
            end

            // look up the register committed last cycle, else a random one
            if (last_cm) begin
                rs1 = last_cm_rd;
            end else begin
                for (k = 0; k < 5; k++) begin
                    rs1[k] = lfsr_bit();
                end
            end
            rs2 = last_rd;

            #1.5;
            exp_fire = alloc_en && !exp_full && !exp_flush;
            check_val("full", 32'(full), 32'(exp_full));
            check_val("alloc_fire", 32'(alloc_fire), 32'(exp_fire));
            check_val("alloc_tag", 32'(alloc_tag), 32'(m_tail));
            check_val("commit_valid", 32'(commit_valid), 32'(exp_cv));
            check_val("store_release", 32'(store_release), 32'(exp_sr));
            check_val("flush", 32'(flush), 32'(exp_flush));
            if (exp_cv) begin
                check_val("commit_tag", 32'(commit_tag), 32'(h));
                check_val("commit_rd", 32'(commit_rd), 32'(m_rd[h]));
                check_val("commit_data", commit_data, m_data[h]);
            end
            if (exp_sr) begin
                check_val("store_tag", 32'(store_tag), 32'(h));
            end
            if (exp_flush) begin
                check_val("redirect_pc", redirect_pc, m_target[h]);
            end
            check_val("rs1_busy", 32'(rs1_busy), 32'(r_busy[rs1]));
            check_val("rs2_busy", 32'(rs2_busy), 32'(r_busy[rs2]));
            if (r_busy[rs1]) begin
                check_val("rs1_tag", 32'(rs1_tag), 32'(r_tag[rs1]));
            end
            if (r_busy[rs2]) begin
                check_val("rs2_tag", 32'(rs2_tag), 32'(r_tag[rs2]));
            end

            // advance the model to the next edge
            if (exp_cv || exp_sr) begin
                commits++;
            end
            last_cm = exp_cv;
            if (exp_cv) begin
                last_cm_rd = m_rd[h];
            end
            saw_full  = saw_full | exp_full;
            saw_flush = saw_flush | exp_flush;
            if (exp_flush) begin
                for (r = 0; r < `REG_COUNT; r++) begin
                    r_busy[r] = 0;
                end
                for (r = 0; r < DEPTH; r++) begin
                    m_done[r] = 0;
                end
                flushed += q_tag.size() - 1;
                q_tag.delete();
                pend_row.delete();
                pend_tag.delete();
                m_tail = '0;
            end else begin
                if (exp_cv && r_busy[m_rd[h]] && r_tag[m_rd[h]] == h) begin
                    r_busy[m_rd[h]] = 0;
                end
                if (exp_cv || exp_sr) begin
                    m_done[h] = 0;
                    void'(q_tag.pop_front());
                end
                if (wb_valid) begin
                    m_done[wb_tag] = 1;
                end
                if (exp_fire) begin
                    if (alloc_rd != '0) begin
                        r_busy[alloc_rd] = 1;
                        r_tag[alloc_rd]  = m_tail;
                    end
                    m_rd[m_tail]     = t_rd[row_idx];
                    m_data[m_tail]   = t_data[row_idx];
                    m_store[m_tail]  = t_store[row_idx];
                    m_mis[m_tail]    = t_branch[row_idx] && (t_pred[row_idx] != t_act[row_idx]);
                    m_target[m_tail] = t_target[row_idx];
                    m_done[m_tail]   = 0;
                    q_tag.push_back(m_tail);
                    pend_row.push_back(row_idx);
                    pend_tag.push_back(m_tail);
                    last_rd = t_rd[row_idx];
                    m_tail  = m_tail + 1'b1;
                    row_idx++;
                end
            end
        end

        alloc_en = 0;
        wb_valid = 0;
        repeat (2) @(posedge clk);
        if (saw_full && saw_flush && commits + flushed == NUM_ROWS) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("run incomplete: full=%0b flush=%0b retired=%0d flushed=%0d",
                     saw_full, saw_flush, commits, flushed);
            $display("Checks failed");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+hdl
hdl/rob_pkg.sv
hdl/wb_bus_if.sv
hdl/commit_if.sv
hdl/rename_table.sv
hdl/reorder_buffer.sv
hdl/rob_core.sv
verification/rob_core_tb.sv

// ==== Makefile ====
# Verilator flow for the reorder buffer subsystem

TB_TOP = rob_core_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f project.f --top-module $(TB_TOP)

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TB_TOP) -o sim_rob
	./obj_dir/sim_rob

clean:
	rm -rf obj_dir
